// ==== emmu_pkg.sv ====
package emmu_pkg;

   // mesh packet and address widths
   localparam int pkt_w     = 104;          // one mesh transaction
   localparam int addr_w    = 32;           // destination address
   localparam int data_w    = 32;           // config data bus
   localparam int hi_w      = 32;           // upper address out, 64-bit mode

   // translation table geometry
   localparam int table_w   = 48;           // entry width
   localparam int table_aw  = 12;           // 4096 entries
   localparam int lane_w    = 8;            // byte lanes
   localparam int lane_n    = table_w / lane_w;
   localparam int page_lsb  = 20;           // dst bits above this index the table
   localparam int page_w    = addr_w - page_lsb;   // entry bits that replace the page

   // config port decode
   localparam int mi_addr_w  = 15;
   localparam int mi_grp_bit = 2;           // 0 -> low lanes, 1 -> upper lanes
   localparam int mi_idx_lsb = mi_addr_w - table_aw;   // entry index is [14:3]
   localparam int lo_lanes   = data_w / lane_w;        // lanes 0..3
   localparam int hi_data_w  = table_w - data_w;       // data bits that feed lanes 4..5

   // lane masks per write group
   localparam logic [lane_n-1:0] lo_lane_mask = lane_n'((1 << lo_lanes) - 1);
   localparam logic [lane_n-1:0] hi_lane_mask = ~lo_lane_mask;

   // packet field positions, bit 0 upward
   localparam int write_pos    = 0;         // write flag
   localparam int datamode_lsb = 1;
   localparam int datamode_w   = 2;
   localparam int ctrlmode_lsb = datamode_lsb + datamode_w;
   localparam int ctrlmode_w   = 5;
   localparam int dst_lsb      = ctrlmode_lsb + ctrlmode_w;   // 8
   localparam int dst_msb      = dst_lsb + addr_w - 1;        // 39
   localparam int data_lsb     = dst_msb + 1;                 // 40
   localparam int data_msb     = data_lsb + data_w - 1;       // 71
   localparam int src_lsb      = data_msb + 1;                // 72
   localparam int src_msb      = src_lsb + addr_w - 1;        // 103, top of packet

endpackage

// ==== mmu_table_if.sv ====
`timescale 1ns/10ps

interface mmu_table_if;
   import emmu_pkg::*;

   // write side, wr_clk domain
   logic [lane_n-1:0]   wr_en;    // one per byte lane
   logic [table_aw-1:0] wr_addr;  // entry index
   logic [table_w-1:0]  wr_data;  // lanes taken from here

   // lookup side, rd_clk domain
   logic                rd_en;    // load rd_data on next edge
   logic [table_aw-1:0] rd_addr;  // page index from dst address
   logic [table_w-1:0]  rd_data;  // registered entry

   // translator drives requests, sees the entry
   modport controller (
      output wr_en, wr_addr, wr_data,
      output rd_en, rd_addr,
      input  rd_data
   );

   // table memory side
   modport memory (
      input  wr_en, wr_addr, wr_data,
      input  rd_en, rd_addr,
      output rd_data
   );

endinterface

// ==== mmu_table.sv ====
`timescale 1ns/10ps

module mmu_table (
   input  logic         wr_clk,   // config clock
   input  logic         rd_clk,   // datapath clock
   mmu_table_if.memory  tbl
);
   import emmu_pkg::*;

   // entries stored as lane_n separately writable bytes
   logic [lane_n-1:0][lane_w-1:0] mem [2**table_aw];

   // lane write, only lanes with wr_en set change
   always_ff @(posedge wr_clk)
   begin
      for (int i = 0; i < lane_n; i++)
      begin
         if (tbl.wr_en[i])
            mem[tbl.wr_addr][i] <= tbl.wr_data[i*lane_w +: lane_w];
      end
   end

   // registered lookup
   // rd_data holds while rd_en is low so a stalled
   // packet keeps its entry lined up
   always_ff @(posedge rd_clk)
   begin
      if (tbl.rd_en)
         tbl.rd_data <= mem[tbl.rd_addr];
   end

endmodule

// ==== emmu.sv ====
`timescale 1ns/10ps

module emmu (
   input  logic                          rd_clk,      // lookup and output stage
   input  logic                          wr_clk,      // config writes
   input  logic                          arst_n,
   input  logic                          mmu_en,      // static level
   input  logic                          mmu_bp,      // bypass, static level
   input  logic                          mi_en,
   input  logic                          mi_we,
   input  logic [emmu_pkg::mi_addr_w-1:0] mi_addr,
   input  logic [emmu_pkg::data_w-1:0]    mi_din,
   input  logic                          access_in,
   input  logic [emmu_pkg::pkt_w-1:0]     packet_in,
   input  logic                          rd_wait,
   input  logic                          wr_wait,
   output logic                          access_out,
   output logic [emmu_pkg::pkt_w-1:0]     packet_out,
   output logic [emmu_pkg::hi_w-1:0]      hi_out,
   mmu_table_if.controller               tbl
);
   import emmu_pkg::*;

   logic                wr_strobe;  // one config write
   logic [lane_n-1:0]   wr_mask;    // lanes of the selected group
   logic                stall;      // either wait level
   logic                take;       // packet accepted this edge
   logic [addr_w-1:0]   dst_in;     // dst field of incoming packet
   logic [pkt_w-1:0]    pkt_q;      // packet held for the splice
   logic [addr_w-1:0]   dst_q;
   logic [addr_w-1:0]   dst_out;    // translated dst field
   logic                xlate;      // translation active

   // config write decode, table writes on the strobe edge
   assign wr_strobe   = mi_en & mi_we;
   assign wr_mask     = mi_addr[mi_grp_bit] ? hi_lane_mask : lo_lane_mask;
   assign tbl.wr_en   = wr_strobe ? wr_mask : '0;
   assign tbl.wr_addr = mi_addr[mi_addr_w-1:mi_idx_lsb];   // entry index [14:3]
   assign tbl.wr_data = {mi_din[hi_data_w-1:0], mi_din};   // low half feeds lanes 4..5

   // lookup request
   assign dst_in      = packet_in[dst_msb:dst_lsb];
   assign stall       = rd_wait | wr_wait;
   assign take        = access_in & ~stall;
   assign tbl.rd_en   = take;                             // no read during stall
   assign tbl.rd_addr = dst_in[addr_w-1:page_lsb];        // page index [31:20]

   // output register, loads on the same edge as the table read
   always_ff @(posedge rd_clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         access_out <= 1'b0;
         pkt_q      <= '0;
      end
      else
      begin
         if (!stall)
            access_out <= access_in;   // idle cycles drop access
         if (take)
            pkt_q <= packet_in;        // stays paired with rd_data
      end
   end

   // address splice, combinational after the edge
   assign xlate = mmu_en & ~mmu_bp;
   assign dst_q = pkt_q[dst_msb:dst_lsb];

   always_comb
   begin
      if (xlate)
      begin
         dst_out = {tbl.rd_data[page_w-1:0], dst_q[page_lsb-1:0]};  // new page, same offset
         hi_out  = tbl.rd_data[page_w +: hi_w];                      // entry [43:12]
      end
      else
      begin
         dst_out = dst_q;    // pass through
         hi_out  = '0;
      end
   end

   // rebuild packet around the new dst field
   assign packet_out = {pkt_q[pkt_w-1:dst_msb+1], dst_out, pkt_q[dst_lsb-1:0]};

endmodule

// ==== emmu_top.sv ====
`timescale 1ns/10ps

module emmu_top (
   input  logic                          rd_clk,
   input  logic                          wr_clk,
   input  logic                          arst_n,
   input  logic                          mmu_en,
   input  logic                          mmu_bp,
   input  logic                          mi_en,
   input  logic                          mi_we,
   input  logic [emmu_pkg::mi_addr_w-1:0] mi_addr,
   input  logic [emmu_pkg::data_w-1:0]    mi_din,
   input  logic                          access_in,
   input  logic [emmu_pkg::pkt_w-1:0]     packet_in,
   input  logic                          rd_wait,
   input  logic                          wr_wait,
   output logic                          access_out,
   output logic [emmu_pkg::pkt_w-1:0]     packet_out,
   output logic [emmu_pkg::hi_w-1:0]      hi_out
);

   // table request and lookup signals
   mmu_table_if i_tbl_if ();

   // decode, lookup request, output stage
   emmu i_emmu (
      .rd_clk     (rd_clk),
      .wr_clk     (wr_clk),
      .arst_n     (arst_n),
      .mmu_en     (mmu_en),
      .mmu_bp     (mmu_bp),
      .mi_en      (mi_en),
      .mi_we      (mi_we),
      .mi_addr    (mi_addr),
      .mi_din     (mi_din),
      .access_in  (access_in),
      .packet_in  (packet_in),
      .rd_wait    (rd_wait),
      .wr_wait    (wr_wait),
      .access_out (access_out),
      .packet_out (packet_out),
      .hi_out     (hi_out),
      .tbl        (i_tbl_if.controller)
   );

   // 4096 x 48 translation table
   mmu_table i_mmu_table (
      .wr_clk (wr_clk),
      .rd_clk (rd_clk),
      .tbl    (i_tbl_if.memory)
   );

endmodule

// ==== emmu_sva.sv ====
`timescale 1ns/10ps

module emmu_sva (
   input logic                       rd_clk,
   input logic                       arst_n,
   input logic                       rd_wait,
   input logic                       wr_wait,
   input logic                       mmu_en,
   input logic                       mmu_bp,
   input logic                       access_out,
   input logic [emmu_pkg::pkt_w-1:0] packet_out,
   input logic [emmu_pkg::hi_w-1:0]  hi_out
);
   import emmu_pkg::*;

   int fail_cnt = 0;   // read by the testbench at the end

   // first cycle out of reset
   a_reset_exit: assert property (@(posedge rd_clk) $rose(arst_n) |-> !access_out)
   else
   begin
      fail_cnt++;
      $error("access_out high in the cycle after reset");
   end

   // stage frozen by either wait
   a_stall_hold: assert property (@(posedge rd_clk) disable iff (!arst_n)
      (rd_wait || wr_wait) |=> ($stable(access_out) && $stable(packet_out) && $stable(hi_out)))
   else
   begin
      fail_cnt++;
      $error("outputs changed while a wait was high");
   end

   // no high address without translation
   a_bypass_hi: assert property (@(posedge rd_clk) disable iff (!arst_n)
      (!mmu_en || mmu_bp) |-> (hi_out == '0))
   else
   begin
      fail_cnt++;
      $error("hi_out not zero while translation is off");
   end

endmodule

// ==== emmu_checker.sv ====
`timescale 1ns/10ps

module emmu_checker (
   input  logic                           rd_clk,
   input  logic                           wr_clk,
   input  logic                           arst_n,
   input  logic                           mmu_en,
   input  logic                           mmu_bp,
   input  logic                           mi_en,
   input  logic                           mi_we,
   input  logic [emmu_pkg::mi_addr_w-1:0] mi_addr,
   input  logic [emmu_pkg::data_w-1:0]    mi_din,
   input  logic                           access_in,
   input  logic [emmu_pkg::pkt_w-1:0]     packet_in,
   input  logic                           rd_wait,
   input  logic                           wr_wait,
   input  logic                           access_out,
   input  logic [emmu_pkg::pkt_w-1:0]     packet_out,
   input  logic [emmu_pkg::hi_w-1:0]      hi_out,
   output int                             err_cnt,
   output int                             chk_cnt
);
   import emmu_pkg::*;

   logic [table_w-1:0] shadow [2**table_aw];   // mirror of the table
   logic               exp_acc;
   logic               have_pkt;                // a packet was accepted since reset
   logic [pkt_w-1:0]   held_pkt;
   logic [table_w-1:0] held_entry;              // entry looked up for held_pkt
   logic [pkt_w-1:0]   exp_pkt;
   logic [hi_w-1:0]    exp_hi;

   initial
   begin
      err_cnt = 0;
      chk_cnt = 0;
   end

   // config writes as seen on the port
   always @(posedge wr_clk)
   begin
      if (mi_en && mi_we)
      begin
         if (mi_addr[2])
            shadow[mi_addr[14:3]][47:32] <= mi_din[15:0];   // upper group
         else
            shadow[mi_addr[14:3]][31:0] <= mi_din;          // low group
      end
   end

   // accept when neither wait is up, hold otherwise
   always @(posedge rd_clk)
   begin
      if (!arst_n)
      begin
         exp_acc  <= 1'b0;
         have_pkt <= 1'b0;
      end
      else if (!rd_wait && !wr_wait)
      begin
         exp_acc <= access_in;
         if (access_in)
         begin
            held_pkt   <= packet_in;
            held_entry <= shadow[packet_in[dst_lsb+31:dst_lsb+20]];
            have_pkt   <= 1'b1;
         end
      end
   end

   // compare mid cycle, outputs settled
   always @(negedge rd_clk)
   begin
      if (arst_n)
      begin
         chk_cnt++;
         if (access_out !== exp_acc)
         begin
            err_cnt++;
            $display("ERROR %0t access_out exp %h got %h", $time, exp_acc, access_out);
         end
         if (have_pkt)
         begin
            exp_pkt = held_pkt;
            exp_hi  = '0;
            if (mmu_en && !mmu_bp)
            begin
               exp_pkt[dst_msb:dst_lsb] = {held_entry[11:0], held_pkt[dst_lsb+19:dst_lsb]};
               exp_hi = held_entry[43:12];
            end
            if (packet_out !== exp_pkt)
            begin
               err_cnt++;
               $display("ERROR %0t packet_out exp %h got %h", $time, exp_pkt, packet_out);
            end
            if (hi_out !== exp_hi)
            begin
               err_cnt++;
               $display("ERROR %0t hi_out exp %h got %h", $time, exp_hi, hi_out);
            end
         end
      end
   end

endmodule

// ==== tb_emmu_top.sv ====
`timescale 1ns/10ps

module tb_emmu_top;
   import emmu_pkg::*;

   typedef enum logic [1:0] {k_write, k_pkt, k_idle} row_kind_t;

   typedef struct packed {
      row_kind_t            kind;
      logic [mi_addr_w-1:0] mi_addr;
      logic [data_w-1:0]    mi_din;
      logic [addr_w-1:0]    dst;      // packet destination
      logic                 en;       // mmu_en
      logic                 bp;       // mmu_bp
      logic [1:0]           waits;    // {wr_wait, rd_wait}
   } row_t;

   logic                 rd_clk = 1'b0;
   logic                 wr_clk = 1'b0;
   logic                 arst_n;
   logic                 mmu_en, mmu_bp;
   logic                 mi_en, mi_we;
   logic [mi_addr_w-1:0] mi_addr;
   logic [data_w-1:0]    mi_din;
   logic                 access_in;
   logic [pkt_w-1:0]     packet_in;
   logic                 rd_wait, wr_wait;
   logic                 access_out;
   logic [pkt_w-1:0]     packet_out;
   logic [hi_w-1:0]      hi_out;

   row_t        rows [$];         // stimulus table
   int          limit;            // cycle budget
   int          cycles = 0;
   int          err_cnt, chk_cnt;
   logic [31:0] rng = 32'h2e89_47d8;
   logic [31:0] body_src, body_data;
   logic [7:0]  body_ctl;        // write flag, datamode, ctrlmode
   logic        held = 1'b0;     // last packet was stalled, keep its body

   always #10 rd_clk = ~rd_clk;
   always #10 wr_clk = ~wr_clk;   // same phase as rd_clk

   emmu_top i_emmu_top (.*);

   emmu_checker i_checker (.*);

   bind emmu emmu_sva i_emmu_sva (
      .rd_clk     (rd_clk),
      .arst_n     (arst_n),
      .rd_wait    (rd_wait),
      .wr_wait    (wr_wait),
      .mmu_en     (mmu_en),
      .mmu_bp     (mmu_bp),
      .access_out (access_out),
      .packet_out (packet_out),
      .hi_out     (hi_out)
   );

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x;
      y = y ^ (y << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   task automatic new_body();
      rng       = xorshift32(rng);
      body_src  = rng;
      rng       = xorshift32(rng);
      body_data = rng;
      rng       = xorshift32(rng);
      body_ctl  = rng[7:0];
   endtask

   task automatic add_write(input logic [11:0] idx, input logic grp, input logic [31:0] din);
      row_t r;
      r         = '0;
      r.kind    = k_write;
      r.mi_addr = {idx, grp, 2'b00};   // entry index, lane group
      r.mi_din  = din;
      rows.push_back(r);
   endtask

   task automatic add_pkt(input logic [31:0] dst, input logic en, input logic bp,
                          input logic [1:0] waits);
      row_t r;
      r       = '0;
      r.kind  = k_pkt;
      r.dst   = dst;
      r.en    = en;
      r.bp    = bp;
      r.waits = waits;
      rows.push_back(r);
   endtask

   task automatic add_idle(input logic en, input logic bp, input logic [1:0] waits);
      row_t r;
      r       = '0;
      r.kind  = k_idle;
      r.en    = en;
      r.bp    = bp;
      r.waits = waits;
      rows.push_back(r);
   endtask

   // drives one row, called just after a rising rd_clk edge
   task automatic apply_row(input row_t r);
      case (r.kind)
         k_write:
         begin
            mi_en     <= 1'b1;
            mi_we     <= 1'b1;
            mi_addr   <= r.mi_addr;
            mi_din    <= r.mi_din;
            access_in <= 1'b0;
            rd_wait   <= 1'b0;
            wr_wait   <= 1'b0;
            @(posedge rd_clk);
            mi_en     <= 1'b0;     // gap so the entry lands before a lookup
            mi_we     <= 1'b0;
         end
         k_pkt:
         begin
            if (!held)
               new_body();
            packet_in <= {body_src, body_data, r.dst, body_ctl};
            access_in <= 1'b1;
            mmu_en    <= r.en;
            mmu_bp    <= r.bp;
            {wr_wait, rd_wait} <= r.waits;
            held = (r.waits != 2'b00);   // upstream holds a stalled packet
         end
         default:
         begin
            access_in <= 1'b0;
            mmu_en    <= r.en;
            mmu_bp    <= r.bp;
            {wr_wait, rd_wait} <= r.waits;
         end
      endcase
   endtask

   // run budget, four cycles per row plus margin
   always @(posedge rd_clk)
   begin
      cycles <= cycles + 1;
      if (cycles >= limit)
      begin
         $display("timeout: test did not finish within %0d cycles", limit);
         $display("Result: FAILED");
         $finish;
      end
   end

   initial
   begin
      arst_n    = 1'b0;
      mmu_en    = 1'b0;
      mmu_bp    = 1'b0;
      mi_en     = 1'b0;
      mi_we     = 1'b0;
      mi_addr   = '0;
      mi_din    = '0;
      access_in = 1'b0;
      packet_in = '0;
      rd_wait   = 1'b0;
      wr_wait   = 1'b0;

      add_write(12'h0a5, 1'b0, 32'h1234_5abc);   // both groups of three entries
      add_write(12'h0a5, 1'b1, 32'h0000_9d7e);
      add_write(12'h3c1, 1'b0, 32'hcafe_0f31);
      add_write(12'h3c1, 1'b1, 32'h0000_4b2a);
      add_write(12'hfff, 1'b0, 32'h0bad_f00d);
      add_write(12'hfff, 1'b1, 32'h0000_ffff);
      add_idle(1'b1, 1'b0, 2'b00);
      add_pkt(32'h0a51_2345, 1'b1, 1'b0, 2'b00);  // back to back translations
      add_pkt(32'h3c1a_bcde, 1'b1, 1'b0, 2'b00);
      add_pkt(32'hfff0_0001, 1'b1, 1'b0, 2'b00);
      add_write(12'h0a5, 1'b0, 32'h8765_4321);   // low group only
      add_pkt(32'h0a5f_ffff, 1'b1, 1'b0, 2'b00);
      add_write(12'h3c1, 1'b1, 32'h0000_1357);   // upper group only
      add_pkt(32'h3c10_0000, 1'b1, 1'b0, 2'b00);
      add_idle(1'b1, 1'b0, 2'b00);               // mode kept while it is on the output
      add_pkt(32'h0a51_1111, 1'b1, 1'b1, 2'b00);  // bypass
      add_pkt(32'h7772_2222, 1'b1, 1'b1, 2'b00);  // bypass, unwritten entry
      add_pkt(32'h3c13_3333, 1'b0, 1'b0, 2'b00);  // mmu off
      add_idle(1'b0, 1'b0, 2'b00);               // still off for its output cycle
      add_pkt(32'hfff4_4444, 1'b1, 1'b0, 2'b00);
      add_pkt(32'h0a55_5555, 1'b1, 1'b0, 2'b01);  // held by rd_wait
      add_pkt(32'h0a55_5555, 1'b1, 1'b0, 2'b10);  // then wr_wait
      add_pkt(32'h0a55_5555, 1'b1, 1'b0, 2'b11);
      add_pkt(32'h0a55_5555, 1'b1, 1'b0, 2'b00);  // release
      add_idle(1'b1, 1'b0, 2'b01);
      add_idle(1'b1, 1'b0, 2'b00);
      add_pkt(32'h3c16_6666, 1'b1, 1'b0, 2'b00);
      add_idle(1'b1, 1'b0, 2'b00);
      limit = 4 * rows.size() + 50;

      repeat (4) @(posedge rd_clk);
      arst_n <= 1'b1;

      foreach (rows[i])
      begin
         @(posedge rd_clk);
         apply_row(rows[i]);
      end

      @(posedge rd_clk);
      access_in <= 1'b0;
      rd_wait   <= 1'b0;
      wr_wait   <= 1'b0;
      repeat (4) @(posedge rd_clk);
      #5;   // past the last compare and the last assertion edge

      $display("checks %0d, value errors %0d, assertion failures %0d",
               chk_cnt, err_cnt, i_emmu_top.i_emmu.i_emmu_sva.fail_cnt);
      if (err_cnt == 0 && i_emmu_top.i_emmu.i_emmu_sva.fail_cnt == 0 && chk_cnt > 0)
         $display("Result: PASSED");
      else
         $display("Result: FAILED");
      $finish;
   end

endmodule

// ==== emmu_top.f ====
emmu_pkg.sv
mmu_table_if.sv
mmu_table.sv
emmu.sv
emmu_top.sv
emmu_sva.sv
emmu_checker.sv
tb_emmu_top.sv

// ==== Bender.yml ====
package:
  name: emmu

sources:
  - emmu_pkg.sv
  - mmu_table_if.sv
  - mmu_table.sv
  - emmu.sv
  - emmu_top.sv
  - target: test
    files:
      - emmu_sva.sv
      - emmu_checker.sv
      - tb_emmu_top.sv
